// File: fetch_unit.f
fetch_riscv_pkg.sv
fetch_core_pkg.sv
fetch_stage1.sv
fetch_imem.sv
fetch_stage2.sv
fetch_unit.sv
tb_fetch_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert -sv --top-module tb_fetch_unit \
        -f fetch_unit.f -o sim_fetch_unit \
    && ./obj_dir/sim_fetch_unit | tee sim.log \
    && grep -q "Verification passed" sim.log \
    || { echo "fetch unit simulation did not pass"; exit 1; }
exit 0

// File: tb_fetch_unit.sv
// Directed testbench for the fetch front end with a transaction-level PC stream model
module tb_fetch_unit;
    timeunit 1ns;
    timeprecision 100ps;

    import fetch_riscv_pkg::*;
    import fetch_core_pkg::*;

    // Cycles any single wait may take
    localparam int WAIT_LIMIT = 64;

    logic     clk;
    logic     rst_n;
    logic     pc_load_en;
    pc_word_t pc_load_val;
    logic     flush;
    logic     stall;
    logic     imem_load_en;
    vaddr_t   imem_load_addr;
    word_t    imem_load_data;
    logic     instr_valid;
    word_t    instr;
    vaddr_t   instr_pc;
    logic     instr_illegal;

    // Copy of the preloaded memory contents
    word_t mirror [IMEM_DEPTH_WORDS];

    // Reference model state
    pc_word_t    exp_q [$];
    pc_word_t    model_pc;
    logic        model_init;
    logic [31:0] lcg_state;

    // Last consumed output as seen by the tests
    int     seen_count;
    vaddr_t last_pc;
    word_t  last_instr;
    logic   last_illegal;

    // Previous cycle outputs for the stall hold check
    logic   prev_stall;
    logic   prev_valid;
    word_t  prev_instr;
    vaddr_t prev_pc;

    int mismatch_count;
    int failure_count;

    fetch_unit fetch_unit_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .pc_load_en     (pc_load_en),
        .pc_load_val    (pc_load_val),
        .flush          (flush),
        .stall          (stall),
        .imem_load_en   (imem_load_en),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_pc       (instr_pc),
        .instr_illegal  (instr_illegal)
    );

    // 40 ns period
    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Upper LCG bits are the better distributed ones
    function automatic int rand_below(input int n);
        logic [31:0] bits;
        bits = lcg_next();
        return int'(bits[30:16]) % n;
    endfunction

    // Legal 32-bit encoding except for about one word in eight
    function automatic word_t make_word();
        word_t       w;
        logic [31:0] sel;
        w   = lcg_next();
        sel = lcg_next();
        if (sel[18:16] == 3'd0) begin
            w[1:0] = 2'b00;
        end else begin
            w[1:0] = OPCODE_LEN32;
        end
        return w;
    endfunction

    function automatic vaddr_t to_byte(input pc_word_t pc);
        return {pc, 2'b00};
    endfunction

    task automatic compare_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_addr(input vaddr_t got, input vaddr_t exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        failure_count++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    // Monitor and model sampled mid-cycle where inputs and outputs are settled
    always @(negedge clk) begin
        pc_word_t    exp_pc;
        imem_index_t idx;
        if (!rst_n) begin
            model_pc   = RESET_PC_WORD;
            model_init = 1'b1;
            prev_stall = 1'b0;
            exp_q.delete();
        end else begin
            // Stalled edge must leave the slot untouched
            if (prev_stall) begin
                compare_flag(instr_valid, prev_valid, "instr_valid across stall");
                compare_word(instr, prev_instr, "instr across stall");
                compare_addr(instr_pc, prev_pc, "instr_pc across stall");
            end
            // A slot counts once on the cycle decode takes it
            if (instr_valid && !stall) begin
                if (exp_q.size() == 0) begin
                    report_failure("instruction delivered with none outstanding");
                end else begin
                    exp_pc = exp_q.pop_front();
                    idx    = exp_pc[IMEM_INDEX_W-1:0];
                    compare_addr(instr_pc, to_byte(exp_pc), "instr_pc");
                    compare_word(instr, mirror[idx], "instr");
                    compare_flag(instr_illegal, mirror[idx][1:0] != OPCODE_LEN32,
                                 "instr_illegal");
                end
                seen_count++;
                last_pc      = instr_pc;
                last_instr   = instr;
                last_illegal = instr_illegal;
            end
            // Advance the PC stream
            if (!stall) begin
                if (model_init) begin
                    compare_flag(instr_valid, 1'b0, "instr_valid in init cycle");
                    model_init = 1'b0;
                end else begin
                    // Flushed slot is dropped but the PC still moves on
                    if (!flush) begin
                        exp_q.push_back(model_pc);
                    end
                    if (pc_load_en) begin
                        model_pc = pc_load_val;
                    end else begin
                        model_pc = model_pc + pc_word_t'(1);
                    end
                end
            end
            // Two cycles of latency never leave more than one slot pending
            if (exp_q.size() > 1) begin
                report_failure("instruction output fell behind its request");
            end
            prev_stall = stall;
            prev_valid = instr_valid;
            prev_instr = instr;
            prev_pc    = instr_pc;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_outputs(input int count);
        int target;
        int cycles;
        target = seen_count + count;
        cycles = 0;
        while (seen_count < target && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (seen_count < target) begin
            report_failure($sformatf("timeout waiting for %0d instructions", count));
        end
    endtask

    task automatic wait_for_pc(input vaddr_t pc);
        int   start;
        int   cycles;
        logic found;
        start  = seen_count;
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
            if (seen_count != start && last_pc == pc) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            report_failure($sformatf("timeout waiting for instruction at %h", pc));
        end
    endtask

    task automatic redirect(input pc_word_t target, input logic with_flush);
        pc_load_en  = 1'b1;
        pc_load_val = target;
        flush       = with_flush;
        next_cycle();
        pc_load_en = 1'b0;
        flush      = 1'b0;
    endtask

    // Preload under reset then the counted reset cycles
    task automatic preload_and_reset();
        imem_index_t idx;
        word_t       w;
        for (int i = 0; i < IMEM_DEPTH_WORDS; i++) begin
            idx         = imem_index_t'(i);
            w           = make_word();
            mirror[idx] = w;
            next_cycle();
            imem_load_en   = 1'b1;
            imem_load_addr = vaddr_t'({idx, 2'b00});
            imem_load_data = w;
        end
        next_cycle();
        imem_load_en = 1'b0;
        repeat (10) next_cycle();
        rst_n = 1'b1;
    endtask

    task automatic test_first_fetch();
        imem_index_t idx;
        idx = RESET_PC_WORD[IMEM_INDEX_W-1:0];
        wait_outputs(1);
        compare_addr(last_pc, to_byte(RESET_PC_WORD), "first PC after reset");
        compare_word(last_instr, mirror[idx], "first instruction after reset");
    endtask

    task automatic test_sequential();
        wait_outputs(20);
    endtask

    task automatic test_redirect();
        logic [31:0] bits;
        pc_word_t    target;
        for (int r = 0; r < 3; r++) begin
            bits   = lcg_next();
            target = bits[31:2];
            redirect(target, 1'b0);
            wait_for_pc(to_byte(target));
            wait_outputs(8);
        end
    endtask

    task automatic test_stall();
        int len;
        for (int r = 0; r < 5; r++) begin
            wait_outputs(3 + rand_below(4));
            len   = 1 + rand_below(6);
            stall = 1'b1;
            repeat (len) next_cycle();
            stall = 1'b0;
        end
        wait_outputs(5);
    endtask

    task automatic test_flush();
        int       len;
        pc_word_t target;
        for (int r = 0; r < 3; r++) begin
            wait_outputs(4);
            len   = 1 + rand_below(4);
            flush = 1'b1;
            repeat (len) next_cycle();
            flush = 1'b0;
        end
        // Redirect in the flush cycle still fetches its target
        wait_outputs(4);
        target = pc_word_t'(rand_below(IMEM_DEPTH_WORDS));
        redirect(target, 1'b1);
        wait_for_pc(to_byte(target));
        wait_outputs(4);
    endtask

    task automatic test_alias_illegal();
        pc_word_t    top;
        pc_word_t    wrapped;
        imem_index_t bad;
        logic        found;
        top     = {22'h15A3C7, 8'hFB};
        wrapped = {22'h15A3C8, 8'h00};
        redirect(top, 1'b0);
        wait_for_pc(to_byte(top));
        // Word index rolls over to entry 0
        wait_for_pc(to_byte(wrapped));
        compare_word(last_instr, mirror[0], "instruction after index wrap");
        found = 1'b0;
        bad   = '0;
        for (int i = 0; i < IMEM_DEPTH_WORDS; i++) begin
            if (!found && mirror[i][1:0] != OPCODE_LEN32) begin
                found = 1'b1;
                bad   = imem_index_t'(i);
            end
        end
        if (!found) begin
            report_failure("no illegal word in the preloaded memory");
        end else begin
            redirect(pc_word_t'(bad), 1'b0);
            wait_for_pc(to_byte(pc_word_t'(bad)));
            compare_flag(last_illegal, 1'b1, "illegal flag on cleared low bits");
        end
        wait_outputs(4);
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        pc_load_en     = 1'b0;
        pc_load_val    = '0;
        flush          = 1'b0;
        stall          = 1'b0;
        imem_load_en   = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;
        lcg_state      = 32'd19;
        seen_count     = 0;
        last_pc        = '0;
        last_instr     = '0;
        last_illegal   = 1'b0;
        mismatch_count = 0;
        failure_count  = 0;

        preload_and_reset();
        test_first_fetch();
        test_sequential();
        test_redirect();
        test_stall();
        test_flush();
        test_alias_illegal();

        $display("Checked %0d instructions: %0d mismatches, %0d other errors",
                 seen_count, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_fetch_unit

// File: fetch_unit.sv
// Fetch front end top joining stage 1, instruction memory and stage 2
module fetch_unit (
    input  logic                      clk,
    input  logic                      rst_n,

    // Redirect
    input  logic                      pc_load_en,
    input  fetch_riscv_pkg::pc_word_t pc_load_val,

    // Hazard levels
    input  logic                      flush,
    input  logic                      stall,

    // Instruction memory preload
    input  logic                      imem_load_en,
    input  fetch_riscv_pkg::vaddr_t   imem_load_addr,
    input  fetch_riscv_pkg::word_t    imem_load_data,

    // Toward decode
    output logic                      instr_valid,
    output fetch_riscv_pkg::word_t    instr,
    output fetch_riscv_pkg::vaddr_t   instr_pc,
    output logic                      instr_illegal
);
    import fetch_riscv_pkg::*;

    // Stage 1 to memory
    logic     req_valid;
    vaddr_t   req_addr;

    // Memory to stage 2
    word_t    rdata;

    // Stage 1 to stage 2
    logic     f1_to_f2_valid;
    pc_word_t f1_to_f2_pc_word;

    fetch_stage1 stage1_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .pc_load_en       (pc_load_en),
        .pc_load_val      (pc_load_val),
        .flush            (flush),
        .stall            (stall),
        .req_valid        (req_valid),
        .req_addr         (req_addr),
        .f1_to_f2_valid   (f1_to_f2_valid),
        .f1_to_f2_pc_word (f1_to_f2_pc_word)
    );

    fetch_imem imem_inst (
        .clk       (clk),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .load_en   (imem_load_en),
        .load_addr (imem_load_addr),
        .load_data (imem_load_data),
        .rdata     (rdata)
    );

    fetch_stage2 stage2_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .stall            (stall),
        .f1_to_f2_valid   (f1_to_f2_valid),
        .f1_to_f2_pc_word (f1_to_f2_pc_word),
        .rdata            (rdata),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .instr_pc         (instr_pc),
        .instr_illegal    (instr_illegal)
    );

endmodule : fetch_unit

// File: fetch_stage2.sv
// Fetch stage 2 pairing returned words with their PC and registering them for decode
module fetch_stage2 (
    input  logic                      clk,
    input  logic                      rst_n,

    // Back-pressure from decode
    input  logic                      stall,

    // From fetch stage 1
    input  logic                      f1_to_f2_valid,
    input  fetch_riscv_pkg::pc_word_t f1_to_f2_pc_word,

    // From instruction memory
    input  fetch_riscv_pkg::word_t    rdata,

    // To decode
    output logic                      instr_valid,
    output fetch_riscv_pkg::word_t    instr,
    output fetch_riscv_pkg::vaddr_t   instr_pc,
    output logic                      instr_illegal
);
    import fetch_riscv_pkg::*;

    logic   valid_q;
    word_t  instr_q;
    vaddr_t pc_q;
    logic   illegal_q;
    vaddr_t pc_byte;
    logic   not_len32;

    // Byte form of the incoming PC
    assign pc_byte = {f1_to_f2_pc_word, {BYTE_OFFSET_W{1'b0}}};

    // Compressed or reserved encodings are not supported
    assign not_len32 = (rdata[LEN_FIELD_W-1:0] != OPCODE_LEN32);

    // Valid bit is the only control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= f1_to_f2_valid;
        end
    end

    // Payload captured on every unstalled edge
    always_ff @(posedge clk) begin
        if (!stall) begin
            instr_q   <= rdata;
            pc_q      <= pc_byte;
            illegal_q <= not_len32;
        end
    end

    assign instr_valid   = valid_q;
    assign instr         = instr_q;
    assign instr_pc      = pc_q;
    assign instr_illegal = illegal_q;

    // Decode sees a frozen slot across a stalled edge
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(instr_valid) && $stable(instr) && $stable(instr_pc))
        else $error("fetch_stage2 output changed during stall");

endmodule : fetch_stage2

// File: fetch_imem.sv
// Behavioural instruction memory with one-cycle synchronous read and a preload write port
module fetch_imem (
    input  logic                    clk,

    // Read port from fetch stage 1
    input  logic                    req_valid,
    input  fetch_riscv_pkg::vaddr_t req_addr,

    // Preload port
    input  logic                    load_en,
    input  fetch_riscv_pkg::vaddr_t load_addr,
    input  fetch_riscv_pkg::word_t  load_data,

    // Read data one cycle after the request
    output fetch_riscv_pkg::word_t  rdata
);
    import fetch_riscv_pkg::*;
    import fetch_core_pkg::*;

    // Storage array
    word_t mem [IMEM_DEPTH_WORDS];

    imem_index_t rd_index;
    imem_index_t wr_index;
    word_t       rdata_q;

    // Low word-address bits select the entry
    // Upper bits alias modulo the depth
    assign rd_index = req_addr[IMEM_INDEX_W+BYTE_OFFSET_W-1:BYTE_OFFSET_W];
    assign wr_index = load_addr[IMEM_INDEX_W+BYTE_OFFSET_W-1:BYTE_OFFSET_W];

    // Preload write
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[wr_index] <= load_data;
        end
    end

    // Registered read
    // Output holds its last word while no read is requested
    // which keeps the stage 2 input stable through a stall
    always_ff @(posedge clk) begin
        if (req_valid) begin
            rdata_q <= mem[rd_index];
        end
    end

    assign rdata = rdata_q;

    // Preload only with word-aligned addresses
    a_load_aligned: assert property (@(posedge clk)
        load_en |-> (load_addr[BYTE_OFFSET_W-1:0] == '0))
        else $error("fetch_imem preload address not word aligned");

endmodule : fetch_imem

// File: fetch_stage1.sv
// Fetch stage 1 holding the word PC, choosing the next PC and issuing memory reads
module fetch_stage1 (
    input  logic                      clk,
    input  logic                      rst_n,

    // Redirect from a later stage
    input  logic                      pc_load_en,
    input  fetch_riscv_pkg::pc_word_t pc_load_val,

    // Hazard levels
    input  logic                      flush,
    input  logic                      stall,

    // Read request to instruction memory
    output logic                      req_valid,
    output fetch_riscv_pkg::vaddr_t   req_addr,

    // PC of the word now on memory rdata
    output logic                      f1_to_f2_valid,
    output fetch_riscv_pkg::pc_word_t f1_to_f2_pc_word
);
    import fetch_riscv_pkg::*;
    import fetch_core_pkg::*;

    logic     init;
    pc_word_t pc_word_q;
    pc_word_t next_seq_pc_word;
    pc_word_t next_pc_word;
    pc_word_t fetch_pc_word;

    // Init flag covers the first request after reset
    // Memory output is not yet meaningful then
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init <= 1'b1;
        end else if (!stall) begin
            init <= 1'b0;
        end
    end

    // Sequential step and redirect select
    always_comb begin
        next_seq_pc_word = pc_word_q + pc_word_t'(1);
        if (pc_load_en) begin
            next_pc_word = pc_load_val;
        end else begin
            next_pc_word = next_seq_pc_word;
        end
    end

    // Re-request the held PC while stalled or during init
    // so that memory output and PC stay paired
    always_comb begin
        if (stall || init) begin
            fetch_pc_word = pc_word_q;
        end else begin
            fetch_pc_word = next_pc_word;
        end
    end

    // PC follows the requested address
    // Next cycle the PC names the word on rdata
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_word_q <= RESET_PC_WORD;
        end else begin
            pc_word_q <= fetch_pc_word;
        end
    end

    // Read enable ignores flush so a redirect target is still fetched
    assign req_valid = !stall;
    assign req_addr  = {fetch_pc_word, {BYTE_OFFSET_W{1'b0}}};

    // Flush only drops the slot handed to stage 2
    assign f1_to_f2_valid   = !stall && !flush && !init;
    assign f1_to_f2_pc_word = pc_word_q;

    // PC frozen across a stalled edge
    a_stall_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> (pc_word_q == $past(pc_word_q)))
        else $error("fetch_stage1 PC moved during stall");

endmodule : fetch_stage1

// File: fetch_core_pkg.sv
// Core configuration constants for reset PC and instruction memory sizing
package fetch_core_pkg;

    // First fetch after reset goes to word 0x10
    // Byte address 0x40
    localparam fetch_riscv_pkg::pc_word_t RESET_PC_WORD = 30'h10;

    // Instruction memory capacity in words
    localparam int IMEM_DEPTH_WORDS = 256;

    // Index width follows from the depth
    localparam int IMEM_INDEX_W = $clog2(IMEM_DEPTH_WORDS);

    // Word index into the instruction memory
    // Higher address bits alias onto the same entries
    typedef logic [IMEM_INDEX_W-1:0] imem_index_t;

endpackage : fetch_core_pkg

// File: fetch_riscv_pkg.sv
// ISA-level widths and instruction encoding constants used across the fetch blocks
package fetch_riscv_pkg;

    // Base integer register and address width
    localparam int XLEN = 32;

    // Instructions are word aligned without the C extension
    localparam int BYTE_OFFSET_W = 2;

    // PC held in word units drops the byte offset bits
    localparam int PC_WORD_W = XLEN - BYTE_OFFSET_W;

    // Width of the low encoding field of an instruction
    localparam int LEN_FIELD_W = 2;

    // Low field value for a standard 32-bit encoding
    localparam logic [LEN_FIELD_W-1:0] OPCODE_LEN32 = 2'b11;

    // One data or instruction word
    typedef logic [XLEN-1:0] word_t;

    // Byte address as seen by the memory side
    typedef logic [XLEN-1:0] vaddr_t;

    // Program counter in word units
    typedef logic [PC_WORD_W-1:0] pc_word_t;

endpackage : fetch_riscv_pkg
